//--- flist.f
dispatchPkg.sv
loadStoreCounter.sv
branchMaskUpdate.sv
resourceCheck.sv
backEndPacketBuild.sv
dispatchReg.sv
dispatch.sv
dispatchTb.sv

//--- Makefile
# Verilator simulation of the four-wide dispatch stage

TOP     = dispatchTb
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR) -f flist.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Finished with no errors" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dispatchTb.sv
/*
 * Dispatch stage testbench
 * Applies a table of occupancy, control and load/store patterns to the
 * dispatch stage. Stall, ready and mask outputs are checked against a
 * model of the capacity and mask rules, and the registered back-end
 * packets are checked one cycle after every bundle.
 */

`timescale 1ns/1ps

module dispatchTb;

  import dispatchPkg::*;

  localparam int ClkPeriod = 20;
  localparam int NumRows   = 24;

  typedef struct packed {
    logic                     renameReady;
    logic                     flagRecover;
    logic                     ctrlVerified;
    checkpointIdT             verifiedId;
    lsqCntT                   loadQ;
    lsqCntT                   storeQ;
    iqCntT                    issueQ;
    alCntT                    activeList;
    logic [DispatchWidth-1:0] loads;     // isLoad per lane
    logic [DispatchWidth-1:0] stores;    // isStore per lane
    logic [3:0]               seedStep;  // LFSR bits skipped before the lane fields
  } stimRowT;

  logic             clk;
  logic             rstN;
  logic             renameReady;
  logic             flagRecover;
  logic             ctrlVerified;
  checkpointIdT     verifiedId;
  renamedBundleT    bundle;
  backEndCntT       backEndCnt;
  issueQBundleT     iqOut;
  activeListBundleT alOut;
  lsqBundleT        lsqOut;
  maskBundleT       maskOut;
  logic             dispatchValid;
  logic             backEndReady;
  logic             stallFrontEnd;

  stimRowT       rows [NumRows];
  logic [31:0]   lfsrState;
  renamedBundleT heldBundle;  // What the output registers should hold
  maskBundleT    heldMask;
  logic          expValid;
  int            checkCount;
  int            errorCount;

  dispatch dut0 (
    .clk                 (clk),
    .rstN_i              (rstN),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecover),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (verifiedId),
    .renamedBundle_i     (bundle),
    .backEndCnt_i        (backEndCnt),
    .issueQBundle_o      (iqOut),
    .activeListBundle_o  (alOut),
    .lsqBundle_o         (lsqOut),
    .updatedBranchMask_o (maskOut),
    .dispatchValid_o     (dispatchValid),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i]    = lfsrState[0];
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
    end
    return val;
  endfunction

  function automatic renamedBundleT makeBundle(input stimRowT r);
    renamedBundleT b;
    void'(takeBits(int'(r.seedStep)));
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      b[lane].pc           = takeBits(PcWidth);
      b[lane].logDest      = LogRegLog'(takeBits(LogRegLog));
      b[lane].destValid    = 1'(takeBits(1));
      b[lane].phyDest      = PhyRegLog'(takeBits(PhyRegLog));
      b[lane].phySrc1      = PhyRegLog'(takeBits(PhyRegLog));
      b[lane].phySrc2      = PhyRegLog'(takeBits(PhyRegLog));
      b[lane].isLoad       = r.loads[lane];
      b[lane].isStore      = r.stores[lane];
      b[lane].branchMask   = branchMaskT'(takeBits(Checkpoints));
      b[lane].checkpointId = checkpointIdT'(takeBits(CheckpointsLog));
      b[lane].imm          = ImmWidth'(takeBits(ImmWidth));
      b[lane].opcode       = OpcodeWidth'(takeBits(OpcodeWidth));
      if (r.ctrlVerified && lane % 2 == 0) begin
        b[lane].branchMask[r.verifiedId] = 1'b1;  // Even lanes always depend on it
      end
    end
    return b;
  endfunction

  function automatic branchMaskT expectedMask(input branchMaskT m, input stimRowT r);
    branchMaskT res;
    res = m;
    for (int bitIdx = 0; bitIdx < Checkpoints; bitIdx++) begin
      if (r.ctrlVerified && bitIdx == int'(r.verifiedId)) begin
        res[bitIdx] = 1'b0;
      end
    end
    return res;
  endfunction

  function automatic logic expectedStall(input stimRowT r);
    return (int'(r.loadQ) + $countones(r.loads) > SizeLsq) ||
           (int'(r.storeQ) + $countones(r.stores) > SizeLsq) ||
           (int'(r.issueQ) + DispatchWidth > SizeIssueQ) ||
           (int'(r.activeList) + DispatchWidth > SizeActiveList);
  endfunction

  function automatic logic expectedReady(input stimRowT r);
    return !expectedStall(r) && r.renameReady && !r.flagRecover;
  endfunction

  task automatic checkCombOutputs(input stimRowT r, input renamedBundleT b, input int rowIdx);
    logic       expStall;
    logic       expReady;
    branchMaskT expMask;
    expStall = expectedStall(r);
    expReady = expectedReady(r);
    checkCount += 2;
    if (stallFrontEnd !== expStall) begin
      errorCount++;
      $display("mismatch at %0t: row %0d stallFrontEnd_o is %b, expected %b",
               $time, rowIdx, stallFrontEnd, expStall);
    end
    if (backEndReady !== expReady) begin
      errorCount++;
      $display("mismatch at %0t: row %0d backEndReady_o is %b, expected %b",
               $time, rowIdx, backEndReady, expReady);
    end
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      expMask = expectedMask(b[lane].branchMask, r);
      checkCount++;
      if (maskOut[lane] !== expMask) begin
        errorCount++;
        $display("mismatch at %0t: row %0d lane %0d updated mask is %h, expected %h",
                 $time, rowIdx, lane, maskOut[lane], expMask);
      end
    end
  endtask

  // Registered outputs against the last accepted bundle
  task automatic checkPackets();
    issueQPktT     expIq;
    activeListPktT expAl;
    lsqPktT        expLsq;
    checkCount++;
    if (dispatchValid !== expValid) begin
      errorCount++;
      $display("mismatch at %0t: dispatchValid_o is %b, expected %b",
               $time, dispatchValid, expValid);
    end
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      expIq.pc           = heldBundle[lane].pc;
      expIq.destValid    = heldBundle[lane].destValid;
      expIq.phyDest      = heldBundle[lane].phyDest;
      expIq.phySrc1      = heldBundle[lane].phySrc1;
      expIq.phySrc2      = heldBundle[lane].phySrc2;
      expIq.isLoad       = heldBundle[lane].isLoad;
      expIq.isStore      = heldBundle[lane].isStore;
      expIq.branchMask   = heldMask[lane];
      expIq.checkpointId = heldBundle[lane].checkpointId;
      expIq.imm          = heldBundle[lane].imm;
      expIq.opcode       = heldBundle[lane].opcode;
      expAl.isLoad       = heldBundle[lane].isLoad;
      expAl.isStore      = heldBundle[lane].isStore;
      expAl.pc           = heldBundle[lane].pc;
      expAl.logDest      = heldBundle[lane].logDest;
      expAl.phyDest      = heldBundle[lane].phyDest;
      expAl.destValid    = heldBundle[lane].destValid;
      expLsq.branchMask  = heldMask[lane];
      expLsq.isStore     = heldBundle[lane].isStore;
      expLsq.isLoad      = heldBundle[lane].isLoad;
      checkCount += 3;
      if (iqOut[lane] !== expIq) begin
        errorCount++;
        $display("mismatch at %0t: lane %0d issue-queue packet is %h, expected %h",
                 $time, lane, iqOut[lane], expIq);
      end
      if (alOut[lane] !== expAl) begin
        errorCount++;
        $display("mismatch at %0t: lane %0d active-list packet is %h, expected %h",
                 $time, lane, alOut[lane], expAl);
      end
      if (lsqOut[lane] !== expLsq) begin
        errorCount++;
        $display("mismatch at %0t: lane %0d LSQ packet is %h, expected %h",
                 $time, lane, lsqOut[lane], expLsq);
      end
    end
  endtask

  // ready, recover, verified, id, loadQ, storeQ, issueQ, activeList, loads, stores, step
  task automatic fillTable();
    rows[0]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd14, 5'd0,  6'd0,  7'd0,  4'b0101, 4'b0010, 4'd3};
    rows[1]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd12, 5'd0,  6'd0,  7'd0,  4'b1111, 4'b0000, 4'd1};
    rows[2]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd13, 5'd0,  6'd0,  7'd0,  4'b1111, 4'b0000, 4'd2};
    rows[3]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd3,  5'd14, 6'd0,  7'd0,  4'b0010, 4'b0101, 4'd5};
    rows[4]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd3,  5'd15, 6'd0,  7'd0,  4'b0010, 4'b0101, 4'd0};
    rows[5]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd0,  5'd0,  6'd28, 7'd10, 4'b0000, 4'b1000, 4'd7};
    rows[6]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd0,  5'd0,  6'd29, 7'd10, 4'b0000, 4'b1000, 4'd4};
    rows[7]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd2,  5'd2,  6'd5,  7'd60, 4'b0100, 4'b0001, 4'd9};
    rows[8]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd2,  5'd2,  6'd5,  7'd61, 4'b0100, 4'b0001, 4'd6};
    rows[9]  = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd16, 5'd0,  6'd0,  7'd0,  4'b0000, 4'b0110, 4'd2};
    rows[10] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd15, 5'd0,  6'd0,  7'd0,  4'b0100, 4'b0000, 4'd8};
    rows[11] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd16, 5'd0,  6'd0,  7'd0,  4'b0100, 4'b0000, 4'd3};
    rows[12] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd16, 5'd0,  6'd0,  7'd0,  4'b1000, 4'b0000, 4'd1};
    rows[13] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd14, 5'd0,  6'd0,  7'd0,  4'b1110, 4'b0000, 4'd4};
    rows[14] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd13, 5'd15, 6'd0,  7'd0,  4'b1110, 4'b0001, 4'd11};
    rows[15] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd0,  5'd14, 6'd0,  7'd0,  4'b0100, 4'b1011, 4'd2};
    rows[16] = '{1'b1, 1'b0, 1'b0, 3'd0, 5'd0,  5'd15, 6'd0,  7'd0,  4'b0000, 4'b1000, 4'd5};
    rows[17] = '{1'b0, 1'b0, 1'b0, 3'd0, 5'd0,  5'd0,  6'd0,  7'd0,  4'b0011, 4'b0000, 4'd3};
    rows[18] = '{1'b1, 1'b1, 1'b0, 3'd0, 5'd0,  5'd0,  6'd0,  7'd0,  4'b0000, 4'b1100, 4'd6};
    rows[19] = '{1'b0, 1'b1, 1'b0, 3'd0, 5'd16, 5'd0,  6'd0,  7'd0,  4'b0001, 4'b0000, 4'd1};
    rows[20] = '{1'b1, 1'b0, 1'b1, 3'd3, 5'd1,  5'd1,  6'd4,  7'd4,  4'b0010, 4'b0100, 4'd7};
    rows[21] = '{1'b1, 1'b0, 1'b1, 3'd7, 5'd0,  5'd0,  6'd0,  7'd0,  4'b1001, 4'b0110, 4'd2};
    rows[22] = '{1'b0, 1'b0, 1'b1, 3'd0, 5'd0,  5'd0,  6'd0,  7'd0,  4'b0001, 4'b0000, 4'd9};
    rows[23] = '{1'b1, 1'b0, 1'b1, 3'd5, 5'd12, 5'd12, 6'd28, 7'd60, 4'b1111, 4'b0000, 4'd3};
  endtask

  initial begin
    stimRowT       cur;
    renamedBundleT curBundle;
    clk          = 1'b0;
    rstN         = 1'b0;
    renameReady  = 1'b1;  // A ready bundle waits while reset holds the registers
    flagRecover  = 1'b0;
    ctrlVerified = 1'b0;
    verifiedId   = '0;
    bundle       = '1;
    backEndCnt   = '0;
    lfsrState    = 32'hdd42_0344;
    heldBundle   = '0;  // Reset state of the output registers
    heldMask     = '0;
    expValid     = 1'b0;
    checkCount   = 0;
    errorCount   = 0;
    fillTable();

    repeat (4) @(posedge clk);
    @(negedge clk);
    checkPackets();  // Still in reset
    @(posedge clk);
    rstN        <= 1'b1;
    renameReady <= 1'b0;

    for (int i = 0; i < NumRows; i++) begin
      cur       = rows[i];
      curBundle = makeBundle(cur);
      @(posedge clk);
      renameReady  <= cur.renameReady;
      flagRecover  <= cur.flagRecover;
      ctrlVerified <= cur.ctrlVerified;
      verifiedId   <= cur.verifiedId;
      bundle       <= curBundle;
      backEndCnt   <= '{loadQ: cur.loadQ, storeQ: cur.storeQ,
                        issueQ: cur.issueQ, activeList: cur.activeList};
      @(negedge clk);
      checkPackets();  // Previous row captured on the last edge
      checkCombOutputs(cur, curBundle, i);
      // Registers load at the coming edge only if this row dispatches
      expValid = expectedReady(cur);
      if (expValid) begin
        heldBundle = curBundle;
        for (int lane = 0; lane < DispatchWidth; lane++) begin
          heldMask[lane] = expectedMask(curBundle[lane].branchMask, cur);
        end
      end
    end

    @(posedge clk);
    renameReady  <= 1'b0;
    flagRecover  <= 1'b0;
    ctrlVerified <= 1'b0;
    @(negedge clk);
    checkPackets();

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Whole run is about NumRows + 7 cycles
  initial begin
    #((NumRows + 20) * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles, %0d errors so far",
             NumRows + 20, errorCount);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- dispatch.sv
/*
 * Four-wide dispatch stage
 * Checks load queue, store queue, issue queue and active list space for
 * the renamed bundle, clears the verified branch checkpoint from each
 * lane's mask and registers the back-end packets. Packets appear one
 * cycle after acceptance together with dispatchValid_o.
 */

`timescale 1ns/1ps

module dispatch (
  input  logic                          clk,
  input  logic                          rstN_i,
  input  logic                          renameReady_i,      // Rename holds a bundle
  input  logic                          flagRecoverEX_i,    // Mispredict recovery in progress
  input  logic                          ctrlVerified_i,
  input  dispatchPkg::checkpointIdT     ctrlVerifiedId_i,
  input  dispatchPkg::renamedBundleT    renamedBundle_i,
  input  dispatchPkg::backEndCntT       backEndCnt_i,       // Current occupancies
  output dispatchPkg::issueQBundleT     issueQBundle_o,
  output dispatchPkg::activeListBundleT activeListBundle_o,
  output dispatchPkg::lsqBundleT        lsqBundle_o,
  output dispatchPkg::maskBundleT       updatedBranchMask_o, // Back to the rename pipeline reg
  output logic                          dispatchValid_o,
  output logic                          backEndReady_o,
  output logic                          stallFrontEnd_o
);

  import dispatchPkg::*;

  laneCntT          loadCnt;
  laneCntT          storeCnt;
  issueQBundleT     issueQBundle;
  activeListBundleT activeListBundle;
  lsqBundleT        lsqBundle;

  loadStoreCounter loadStoreCounter0 (
    .renamedBundle_i (renamedBundle_i),
    .loadCnt_o       (loadCnt),
    .storeCnt_o      (storeCnt)
  );

  branchMaskUpdate branchMaskUpdate0 (
    .renamedBundle_i  (renamedBundle_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .updatedMask_o    (updatedBranchMask_o)
  );

  resourceCheck resourceCheck0 (
    .backEndCnt_i    (backEndCnt_i),
    .loadCnt_i       (loadCnt),
    .storeCnt_i      (storeCnt),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .stallFrontEnd_o (stallFrontEnd_o),
    .backEndReady_o  (backEndReady_o)
  );

  backEndPacketBuild backEndPacketBuild0 (
    .renamedBundle_i    (renamedBundle_i),
    .updatedMask_i      (updatedBranchMask_o),
    .issueQBundle_o     (issueQBundle),
    .activeListBundle_o (activeListBundle),
    .lsqBundle_o        (lsqBundle)
  );

  dispatchReg #(.payloadT(issueQBundleT)) issueQReg0 (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (issueQBundle),
    .payload_o (issueQBundle_o),
    .valid_o   ()
  );

  // This instance provides the stage valid
  dispatchReg #(.payloadT(activeListBundleT)) activeListReg0 (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (activeListBundle),
    .payload_o (activeListBundle_o),
    .valid_o   (dispatchValid_o)
  );

  dispatchReg #(.payloadT(lsqBundleT)) lsqReg0 (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (backEndReady_o),
    .payload_i (lsqBundle),
    .payload_o (lsqBundle_o),
    .valid_o   ()
  );

endmodule

//--- dispatchReg.sv
/*
 * Dispatch output register
 * Pipeline register between dispatch and one back-end structure. Holds
 * its payload until the next dispatch and flags the cycle after a load.
 */

`timescale 1ns/1ps

module dispatchReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN_i,
  input  logic    load_i,     // Bundle accepted this cycle
  input  payloadT payload_i,
  output payloadT payload_o,
  output logic    valid_o
);

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      payload_o <= '0;
      valid_o   <= 1'b0;
    end else begin
      valid_o <= load_i;
      if (load_i) begin
        payload_o <= payload_i;  // Otherwise hold the last bundle
      end
    end
  end

endmodule

//--- backEndPacketBuild.sv
/*
 * Back-end packet builder
 * Maps each renamed lane into the issue-queue, active-list and load-store
 * queue payload formats. The issue-queue and LSQ payloads carry the branch
 * mask with the verified checkpoint already cleared.
 */

`timescale 1ns/1ps

module backEndPacketBuild (
  input  dispatchPkg::renamedBundleT    renamedBundle_i,
  input  dispatchPkg::maskBundleT       updatedMask_i,
  output dispatchPkg::issueQBundleT     issueQBundle_o,
  output dispatchPkg::activeListBundleT activeListBundle_o,
  output dispatchPkg::lsqBundleT        lsqBundle_o
);

  import dispatchPkg::*;

  // Issue queue gets everything needed for wakeup, select and execute
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      issueQBundle_o[lane].pc           = renamedBundle_i[lane].pc;
      issueQBundle_o[lane].destValid    = renamedBundle_i[lane].destValid;
      issueQBundle_o[lane].phyDest      = renamedBundle_i[lane].phyDest;
      issueQBundle_o[lane].phySrc1      = renamedBundle_i[lane].phySrc1;
      issueQBundle_o[lane].phySrc2      = renamedBundle_i[lane].phySrc2;
      issueQBundle_o[lane].isLoad       = renamedBundle_i[lane].isLoad;
      issueQBundle_o[lane].isStore      = renamedBundle_i[lane].isStore;
      issueQBundle_o[lane].branchMask   = updatedMask_i[lane];
      issueQBundle_o[lane].checkpointId = renamedBundle_i[lane].checkpointId;
      issueQBundle_o[lane].imm          = renamedBundle_i[lane].imm;
      issueQBundle_o[lane].opcode       = renamedBundle_i[lane].opcode;
    end
  end

  // Active list keeps what commit and register freeing need
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      activeListBundle_o[lane].isLoad    = renamedBundle_i[lane].isLoad;
      activeListBundle_o[lane].isStore   = renamedBundle_i[lane].isStore;
      activeListBundle_o[lane].pc        = renamedBundle_i[lane].pc;
      activeListBundle_o[lane].logDest   = renamedBundle_i[lane].logDest;
      activeListBundle_o[lane].phyDest   = renamedBundle_i[lane].phyDest;
      activeListBundle_o[lane].destValid = renamedBundle_i[lane].destValid;
    end
  end

  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      lsqBundle_o[lane].branchMask = updatedMask_i[lane];  // For squash on mispredict
      lsqBundle_o[lane].isStore    = renamedBundle_i[lane].isStore;
      lsqBundle_o[lane].isLoad     = renamedBundle_i[lane].isLoad;
    end
  end

endmodule

//--- resourceCheck.sv
/*
 * Back-end resource check
 * Compares the occupancy of the load queue, store queue, issue queue and
 * active list plus the demand of the current bundle against capacity.
 * Any overflow stalls the front end; otherwise the bundle is dispatched
 * when rename has one ready and no recovery is in progress.
 */

`timescale 1ns/1ps

module resourceCheck (
  input  dispatchPkg::backEndCntT backEndCnt_i,
  input  dispatchPkg::laneCntT    loadCnt_i,
  input  dispatchPkg::laneCntT    storeCnt_i,
  input  logic                    renameReady_i,
  input  logic                    flagRecoverEX_i,
  output logic                    stallFrontEnd_o,
  output logic                    backEndReady_o   // Also the dispatch register enable
);

  import dispatchPkg::*;

  // One extra bit so the sums cannot wrap
  logic [LsqCntWidth:0] loadSum;
  logic [LsqCntWidth:0] storeSum;
  logic [IqCntWidth:0]  issueQSum;
  logic [AlCntWidth:0]  activeListSum;

  logic loadFull;
  logic storeFull;
  logic issueQFull;
  logic activeListFull;

  always_comb begin
    loadSum       = (LsqCntWidth+1)'(backEndCnt_i.loadQ) + (LsqCntWidth+1)'(loadCnt_i);
    storeSum      = (LsqCntWidth+1)'(backEndCnt_i.storeQ) + (LsqCntWidth+1)'(storeCnt_i);
    // Issue queue and active list reserve a full bundle every time
    issueQSum     = (IqCntWidth+1)'(backEndCnt_i.issueQ) + (IqCntWidth+1)'(DispatchWidth);
    activeListSum = (AlCntWidth+1)'(backEndCnt_i.activeList) + (AlCntWidth+1)'(DispatchWidth);
  end

  assign loadFull       = loadSum > (LsqCntWidth+1)'(SizeLsq);
  assign storeFull      = storeSum > (LsqCntWidth+1)'(SizeLsq);
  assign issueQFull     = issueQSum > (IqCntWidth+1)'(SizeIssueQ);
  assign activeListFull = activeListSum > (AlCntWidth+1)'(SizeActiveList);

  assign stallFrontEnd_o = loadFull | storeFull | issueQFull | activeListFull;
  assign backEndReady_o  = ~stallFrontEnd_o & renameReady_i & ~flagRecoverEX_i;

endmodule

//--- branchMaskUpdate.sv
/*
 * Branch mask update
 * When a branch resolves correctly in execute, its checkpoint bit is
 * removed from the mask of every instruction still waiting in dispatch,
 * so those instructions no longer depend on it.
 */

`timescale 1ns/1ps

module branchMaskUpdate (
  input  dispatchPkg::renamedBundleT renamedBundle_i,
  input  logic                       ctrlVerified_i,    // Branch resolved as predicted
  input  dispatchPkg::checkpointIdT  ctrlVerifiedId_i,  // Its checkpoint
  output dispatchPkg::maskBundleT    updatedMask_o
);

  import dispatchPkg::*;

  branchMaskT clearMask;  // One-hot bit to drop, or zero

  always_comb begin
    clearMask = '0;
    if (ctrlVerified_i) begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      updatedMask_o[lane] = renamedBundle_i[lane].branchMask & ~clearMask;
    end
  end

endmodule

//--- loadStoreCounter.sv
/*
 * Load/store demand counter
 * Pulls the load and store flag out of every lane of the renamed bundle
 * and counts how many load-queue and store-queue entries it needs.
 */

`timescale 1ns/1ps

module loadStoreCounter (
  input  dispatchPkg::renamedBundleT renamedBundle_i,
  output dispatchPkg::laneCntT       loadCnt_o,
  output dispatchPkg::laneCntT       storeCnt_o
);

  import dispatchPkg::*;

  logic [DispatchWidth-1:0] loadFlags;   // One bit per lane
  logic [DispatchWidth-1:0] storeFlags;

  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      loadFlags[lane]  = renamedBundle_i[lane].isLoad;
      storeFlags[lane] = renamedBundle_i[lane].isStore;
    end
  end

  // Population count of each flag vector
  always_comb begin
    loadCnt_o  = '0;
    storeCnt_o = '0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      loadCnt_o  = loadCnt_o + laneCntT'(loadFlags[lane]);
      storeCnt_o = storeCnt_o + laneCntT'(storeFlags[lane]);
    end
  end

endmodule

//--- dispatchPkg.sv
/*
 * Dispatch stage shared definitions
 * Sizes of the back-end structures, the renamed instruction format, the
 * issue-queue, active-list and load-store-queue payloads and the occupancy
 * counts used by the four-wide dispatch stage.
 */

package dispatchPkg;

  // Machine configuration
  localparam int DispatchWidth  = 4;
  localparam int Checkpoints    = 8;
  localparam int CheckpointsLog = 3;
  localparam int PhyRegLog      = 7;
  localparam int LogRegLog      = 5;
  localparam int PcWidth        = 32;
  localparam int ImmWidth       = 16;
  localparam int OpcodeWidth    = 8;

  // Back-end capacities
  localparam int SizeLsq        = 16;  // Entries per load or store queue
  localparam int SizeIssueQ     = 32;
  localparam int SizeActiveList = 64;

  // Occupancy widths, each wide enough to hold the full capacity
  localparam int LsqCntWidth    = $clog2(SizeLsq) + 1;
  localparam int IqCntWidth     = $clog2(SizeIssueQ) + 1;
  localparam int AlCntWidth     = $clog2(SizeActiveList) + 1;
  localparam int LaneCntWidth   = $clog2(DispatchWidth) + 1;

  typedef logic [LsqCntWidth-1:0]    lsqCntT;
  typedef logic [IqCntWidth-1:0]     iqCntT;
  typedef logic [AlCntWidth-1:0]     alCntT;
  typedef logic [LaneCntWidth-1:0]   laneCntT;

  typedef logic [Checkpoints-1:0]    branchMaskT;
  typedef logic [CheckpointsLog-1:0] checkpointIdT;

  typedef struct packed {
    logic [PcWidth-1:0]     pc;
    logic [LogRegLog-1:0]   logDest;
    logic                   destValid;
    logic [PhyRegLog-1:0]   phyDest;
    logic [PhyRegLog-1:0]   phySrc1;
    logic [PhyRegLog-1:0]   phySrc2;
    logic                   isLoad;
    logic                   isStore;
    branchMaskT             branchMask;   // Unresolved branches this op depends on
    checkpointIdT           checkpointId;
    logic [ImmWidth-1:0]    imm;
    logic [OpcodeWidth-1:0] opcode;
  } renamedPktT;

  // Issue queue never needs the architectural destination
  typedef struct packed {
    logic [PcWidth-1:0]     pc;
    logic                   destValid;
    logic [PhyRegLog-1:0]   phyDest;
    logic [PhyRegLog-1:0]   phySrc1;
    logic [PhyRegLog-1:0]   phySrc2;
    logic                   isLoad;
    logic                   isStore;
    branchMaskT             branchMask;   // Already has the verified bit cleared
    checkpointIdT           checkpointId;
    logic [ImmWidth-1:0]    imm;
    logic [OpcodeWidth-1:0] opcode;
  } issueQPktT;

  typedef struct packed {
    logic                 isLoad;
    logic                 isStore;
    logic [PcWidth-1:0]   pc;
    logic [LogRegLog-1:0] logDest;
    logic [PhyRegLog-1:0] phyDest;
    logic                 destValid;
  } activeListPktT;

  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPktT;

  typedef renamedPktT    [DispatchWidth-1:0] renamedBundleT;
  typedef issueQPktT     [DispatchWidth-1:0] issueQBundleT;
  typedef activeListPktT [DispatchWidth-1:0] activeListBundleT;
  typedef lsqPktT        [DispatchWidth-1:0] lsqBundleT;
  typedef branchMaskT    [DispatchWidth-1:0] maskBundleT;

  typedef struct packed {
    lsqCntT loadQ;
    lsqCntT storeQ;
    iqCntT  issueQ;
    alCntT  activeList;
  } backEndCntT;

endpackage
